// ==== src/mod_pkg.sv ====
// Shared widths, register map and encodings for the modulus peripheral
// Built for a single width pair only, no per-module overrides
// Register offsets are byte addresses, accesses must be word aligned
// Partial-word writes are not supported, wstrb is ignored

package mod_pkg;

	//--------------------------------------------------------------------------
	// Datapath and bus widths
	//--------------------------------------------------------------------------
	localparam int A_WIDTH    = 14;                 // Dividend
	localparam int B_WIDTH    = 9;                  // Divisor and result
	localparam int DATA_WIDTH = 32;                 // AXI data
	localparam int ADDR_WIDTH = 5;                  // AXI byte address
	localparam int CNT_WIDTH  = $clog2(A_WIDTH);    // Divider bit counter

	//--------------------------------------------------------------------------
	// Register map
	//--------------------------------------------------------------------------
	localparam logic [ADDR_WIDTH-1:0] REG_A      = 5'h00;
	localparam logic [ADDR_WIDTH-1:0] REG_B      = 5'h04;
	localparam logic [ADDR_WIDTH-1:0] REG_CTRL   = 5'h08;  // go, tc, op
	localparam logic [ADDR_WIDTH-1:0] REG_STATUS = 5'h0C;  // busy, done, div_zero
	localparam logic [ADDR_WIDTH-1:0] REG_RESULT = 5'h10;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// CTRL bit 2
	typedef enum logic {
		OP_MOD = 1'b0,    // Sign follows divisor
		OP_REM = 1'b1     // Sign follows dividend
	} op_e;

	// Sequential divider phases
	typedef enum logic [1:0] {
		DIV_IDLE = 2'd0,
		DIV_RUN  = 2'd1,
		DIV_FIX  = 2'd2
	} div_state_e;

endpackage

// ==== src/nr_divider.sv ====
// Sequential shift/subtract non-restoring divider, remainder only
// Inputs are unsigned magnitudes, sampled on div_start while idle
// One dividend bit per clock, div_done pulses A_WIDTH+1 cycles after start
// A zero divisor gives a meaningless remainder, caller must mask it
// div_start while busy is ignored

`timescale 1ns/1ps

module nr_divider
	import mod_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               div_start,
	input  logic [A_WIDTH-1:0] a_mag,
	input  logic [B_WIDTH-1:0] b_mag,
	output logic               div_busy,
	output logic               div_done,
	output logic [B_WIDTH-1:0] rem_mag
);

	div_state_e           state;
	logic [CNT_WIDTH-1:0] bit_cnt;      // Dividend bits retired
	logic [B_WIDTH:0]     part_rem;     // Signed partial remainder, one guard bit
	logic [A_WIDTH-1:0]   dvd_sr;       // Remaining dividend bits, MSB first
	logic [B_WIDTH-1:0]   dvs;          // Held divisor
	logic [B_WIDTH:0]     shifted;
	logic [B_WIDTH:0]     step_sum;
	logic [B_WIDTH:0]     fix_sum;

	// Bring the next dividend bit into the partial remainder
	assign shifted  = {part_rem[B_WIDTH-1:0], dvd_sr[A_WIDTH-1]};
	// Negative remainder adds the divisor back, otherwise subtract
	assign step_sum = part_rem[B_WIDTH] ? shifted + {1'b0, dvs} : shifted - {1'b0, dvs};
	assign fix_sum  = part_rem[B_WIDTH] ? part_rem + {1'b0, dvs} : part_rem;  // Final restore

	assign div_busy = (state != DIV_IDLE);

	//--------------------------------------------------------------------------
	// Control FSM
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= DIV_IDLE;
			bit_cnt  <= '0;
			div_done <= 1'b0;
		end
		else
		begin
			div_done <= 1'b0;                   // Single cycle pulse
			case (state)
				DIV_IDLE:
					if (div_start)
					begin
						state   <= DIV_RUN;         // Load cycle
						bit_cnt <= '0;
					end
				DIV_RUN:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == CNT_WIDTH'(A_WIDTH - 1))
						state <= DIV_FIX;           // Last bit retired
				end
				DIV_FIX:
				begin
					state    <= DIV_IDLE;
					div_done <= 1'b1;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	//--------------------------------------------------------------------------
	// Datapath
	//--------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		case (state)
			DIV_IDLE:
				if (div_start)
				begin
					part_rem <= '0;                 // First step always subtracts
					dvd_sr   <= a_mag;
					dvs      <= b_mag;
				end
			DIV_RUN:
			begin
				part_rem <= step_sum;
				dvd_sr   <= {dvd_sr[A_WIDTH-2:0], 1'b0};
			end
			DIV_FIX: rem_mag <= fix_sum[B_WIDTH-1:0];  // Always non-negative here
			default: ;
		endcase
	end

endmodule

// ==== src/mod_unit.sv ====
// Signed/unsigned VHDL mod and rem around the sequential divider
// Operands are sampled on start, later changes do not affect the run
// done pulses one cycle after the divider, 16 cycles after start
// Zero divisor runs the full latency, then gives 0 with div_zero set

`timescale 1ns/1ps

module mod_unit
	import mod_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic [A_WIDTH-1:0] op_a,
	input  logic [B_WIDTH-1:0] op_b,
	input  logic               tc,
	input  op_e                op,
	output logic               busy,
	output logic               done,
	output logic [B_WIDTH-1:0] result,
	output logic               div_zero
);

	logic               div_start;
	logic               div_busy;
	logic               div_done;
	logic [A_WIDTH-1:0] a_mag;
	logic [B_WIDTH-1:0] b_mag;
	logic [B_WIDTH-1:0] rem_mag;
	logic               a_neg_in;
	logic               b_neg_in;
	logic               a_neg;          // Captured sign flags
	logic               b_neg;
	logic               b_zero;
	op_e                op_q;
	logic [B_WIDTH-1:0] b_mag_q;
	logic [B_WIDTH-1:0] mod_mag;
	logic [B_WIDTH-1:0] res_mag;
	logic               res_neg;
	logic [B_WIDTH-1:0] res_next;

	assign div_start = start & ~busy & ~div_busy;   // One operation in flight
	assign a_neg_in  = tc & op_a[A_WIDTH-1];
	assign b_neg_in  = tc & op_b[B_WIDTH-1];
	assign a_mag     = a_neg_in ? ~op_a + 1'b1 : op_a;  // Most negative value still fits
	assign b_mag     = b_neg_in ? ~op_b + 1'b1 : op_b;
	assign mod_mag   = b_mag_q - rem_mag;         // Distance to next divisor multiple

	nr_divider u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.div_start (div_start),
		.a_mag     (a_mag),
		.b_mag     (b_mag),
		.div_busy  (div_busy),
		.div_done  (div_done),
		.rem_mag   (rem_mag)
	);

	// Sign rules
	always_comb
	begin
		res_mag = rem_mag;
		res_neg = a_neg;                            // rem follows dividend
		if (op_q == OP_MOD)
		begin
			res_neg = b_neg;                        // mod follows divisor
			if ((rem_mag != '0) && (a_neg != b_neg))
				res_mag = mod_mag;
		end
		if (b_zero)
			res_next = '0;
		else if (res_neg)
			res_next = ~res_mag + 1'b1;
		else
			res_next = res_mag;
	end

	always_ff @(posedge clk)
	begin
		if (div_start)
		begin
			a_neg   <= a_neg_in;
			b_neg   <= b_neg_in;
			b_zero  <= (op_b == '0);
			op_q    <= op;
			b_mag_q <= b_mag;
		end
		if (div_done)
			result <= res_next;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy     <= 1'b0;
			done     <= 1'b0;
			div_zero <= 1'b0;
		end
		else
		begin
			done <= div_done;                       // Aligned with registered result
			if (div_start)
				busy <= 1'b1;
			else if (div_done)
				busy <= 1'b0;                       // Already low while done is high
			if (div_done)
				div_zero <= b_zero;
		end
	end

endmodule

// ==== src/axil_mod_regs.sv ====
// AXI4-Lite register block for the modulus peripheral
// Single outstanding transaction per channel, no bursts
// wstrb is ignored, every write updates the full register
// Unmapped or unaligned offsets answer SLVERR, reads of them return 0
// Writes to STATUS and RESULT are accepted with OKAY and have no effect
// CTRL go is dropped without error while an operation runs

`timescale 1ns/1ps

module axil_mod_regs
	import mod_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	// AXI4-Lite slave
	input  logic [ADDR_WIDTH-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [DATA_WIDTH-1:0]   wdata,
	input  logic [DATA_WIDTH/8-1:0] wstrb,      // Not used, full writes only
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [ADDR_WIDTH-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [DATA_WIDTH-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready,
	// Arithmetic unit
	output logic [A_WIDTH-1:0]      op_a,
	output logic [B_WIDTH-1:0]      op_b,
	output logic                    tc,
	output op_e                     op,
	output logic                    start,
	input  logic                    busy,
	input  logic                    done,
	input  logic [B_WIDTH-1:0]      result,
	input  logic                    div_zero
);

	logic                  wr_hs;
	logic                  rd_hs;
	logic                  done_q;      // Sticky until next start
	logic                  zero_q;
	logic                  last_tc;     // tc of the running or last operation
	logic [B_WIDTH-1:0]    result_q;
	logic [DATA_WIDTH-1:0] rd_word;

	function automatic logic is_mapped(input logic [ADDR_WIDTH-1:0] addr);
		return (addr == REG_A) || (addr == REG_B) || (addr == REG_CTRL) ||
			(addr == REG_STATUS) || (addr == REG_RESULT);
	endfunction

	assign wr_hs = awvalid & awready & wvalid & wready;
	assign rd_hs = arvalid & arready;

	//--------------------------------------------------------------------------
	// Write channel and register fields
	//--------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= RESP_OKAY;
			op_a    <= '0;
			op_b    <= '0;
			tc      <= 1'b0;
			op      <= OP_MOD;
			start   <= 1'b0;
			last_tc <= 1'b0;
		end
		else
		begin
			awready <= awvalid & wvalid & ~awready & ~bvalid;   // Both channels together
			wready  <= awvalid & wvalid & ~awready & ~bvalid;
			start   <= 1'b0;
			if (wr_hs)
			begin
				bvalid <= 1'b1;
				bresp  <= is_mapped(awaddr) ? RESP_OKAY : RESP_SLVERR;
				case (awaddr)
					REG_A: op_a <= wdata[A_WIDTH-1:0];
					REG_B: op_b <= wdata[B_WIDTH-1:0];
					REG_CTRL:
					begin
						tc <= wdata[1];
						op <= op_e'(wdata[2]);
						if (wdata[0] && !busy)      // go, self clearing
						begin
							start   <= 1'b1;
							last_tc <= wdata[1];
						end
					end
					default: ;                      // STATUS, RESULT, unmapped
				endcase
			end
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	// Status capture
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			done_q   <= 1'b0;
			zero_q   <= 1'b0;
			result_q <= '0;
		end
		else if (start)
			done_q <= 1'b0;
		else if (done)
		begin
			done_q   <= 1'b1;
			zero_q   <= div_zero;
			result_q <= result;
		end
	end

	//--------------------------------------------------------------------------
	// Read channel
	//--------------------------------------------------------------------------
	always_comb
	begin
		case (araddr)
			REG_A:      rd_word = DATA_WIDTH'(op_a);
			REG_B:      rd_word = DATA_WIDTH'(op_b);
			REG_CTRL:   rd_word = DATA_WIDTH'({op, tc, 1'b0});     // go reads 0
			REG_STATUS: rd_word = DATA_WIDTH'({zero_q, done_q, busy});
			REG_RESULT:
				if (last_tc)
					rd_word = {{(DATA_WIDTH - B_WIDTH){result_q[B_WIDTH-1]}}, result_q};
				else
					rd_word = DATA_WIDTH'(result_q);
			default:    rd_word = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= RESP_OKAY;
		end
		else
		begin
			arready <= arvalid & ~arready & ~rvalid;
			if (rd_hs)
			begin
				rvalid <= 1'b1;
				rdata  <= rd_word;
				rresp  <= is_mapped(araddr) ? RESP_OKAY : RESP_SLVERR;
			end
			else if (rvalid && rready)
				rvalid <= 1'b0;                     // Held until accepted
		end
	end

endmodule

// ==== src/mod_periph_top.sv ====
// Modulus peripheral top, AXI4-Lite register block plus arithmetic unit
// One operation at a time, status polled by the host, no interrupt

`timescale 1ns/1ps

module mod_periph_top
	import mod_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [ADDR_WIDTH-1:0]   awaddr,
	input  logic                    awvalid,
	output logic                    awready,
	input  logic [DATA_WIDTH-1:0]   wdata,
	input  logic [DATA_WIDTH/8-1:0] wstrb,
	input  logic                    wvalid,
	output logic                    wready,
	output logic [1:0]              bresp,
	output logic                    bvalid,
	input  logic                    bready,
	input  logic [ADDR_WIDTH-1:0]   araddr,
	input  logic                    arvalid,
	output logic                    arready,
	output logic [DATA_WIDTH-1:0]   rdata,
	output logic [1:0]              rresp,
	output logic                    rvalid,
	input  logic                    rready
);

	logic [A_WIDTH-1:0] op_a;
	logic [B_WIDTH-1:0] op_b;
	logic               tc;
	op_e                op;
	logic               start;      // One cycle, register block to unit
	logic               busy;
	logic               done;       // One cycle, unit to register block
	logic [B_WIDTH-1:0] result;
	logic               div_zero;

	axil_mod_regs u_regs (
		.clk      (clk),      .rst_n    (rst_n),
		.awaddr   (awaddr),   .awvalid  (awvalid),  .awready  (awready),
		.wdata    (wdata),    .wstrb    (wstrb),    .wvalid   (wvalid),   .wready (wready),
		.bresp    (bresp),    .bvalid   (bvalid),   .bready   (bready),
		.araddr   (araddr),   .arvalid  (arvalid),  .arready  (arready),
		.rdata    (rdata),    .rresp    (rresp),    .rvalid   (rvalid),   .rready (rready),
		.op_a     (op_a),     .op_b     (op_b),     .tc       (tc),       .op     (op),
		.start    (start),    .busy     (busy),     .done     (done),
		.result   (result),   .div_zero (div_zero)
	);

	mod_unit u_mod (
		.clk      (clk),      .rst_n    (rst_n),
		.start    (start),    .op_a     (op_a),     .op_b     (op_b),
		.tc       (tc),       .op       (op),
		.busy     (busy),     .done     (done),
		.result   (result),   .div_zero (div_zero)
	);

endmodule

// ==== dv/mod_periph_assertions.sv ====
// Protocol and control checks bound into the register block
// Checks are held off while reset is asserted

`timescale 1ns/1ps

module mod_periph_assertions (
	input logic clk,
	input logic rst_n,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic start,
	input logic busy,
	input logic done
);

	// Responses stay up until taken
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(start) |-> !busy) else $error("start raised while busy");
	a_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !busy) else $error("busy still high with done");

endmodule

bind axil_mod_regs mod_periph_assertions u_assertions (
	.clk     (clk),
	.rst_n   (rst_n),
	.bvalid  (bvalid),
	.bready  (bready),
	.rvalid  (rvalid),
	.rready  (rready),
	.start   (start),
	.busy    (busy),
	.done    (done)
);

// ==== dv/tb_mod_periph.sv ====
// Testbench for the modulus peripheral, driven over AXI4-Lite only
// Inputs change 1 ns after the rising edge, outputs sampled there too
// Completion is found by polling STATUS.done, never by counting cycles
// Random cases use a fixed seed so every run is the same

`timescale 1ns/1ps

module tb_mod_periph
	import mod_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int N_RANDOM   = 20;
	localparam int MAX_POLLS  = 40;     // STATUS reads before giving up

	logic                    clk;
	logic                    rst_n;
	logic [ADDR_WIDTH-1:0]   awaddr;
	logic                    awvalid;
	logic                    awready;
	logic [DATA_WIDTH-1:0]   wdata;
	logic [DATA_WIDTH/8-1:0] wstrb;
	logic                    wvalid;
	logic                    wready;
	logic [1:0]              bresp;
	logic                    bvalid;
	logic                    bready;
	logic [ADDR_WIDTH-1:0]   araddr;
	logic                    arvalid;
	logic                    arready;
	logic [DATA_WIDTH-1:0]   rdata;
	logic [1:0]              rresp;
	logic                    rvalid;
	logic                    rready;

	// Stimulus table, one entry per operation
	logic [A_WIDTH-1:0]    tbl_a[$];
	logic [B_WIDTH-1:0]    tbl_b[$];
	logic                  tbl_tc[$];
	op_e                   tbl_op[$];
	logic [DATA_WIDTH-1:0] tbl_exp[$];
	logic                  tbl_zero[$];
	logic [1:0]            tbl_resp[$];
	logic                  tbl_ready = 1'b0;

	int seed     = 94517;
	int errors   = 0;
	int checks   = 0;
	int n_tests  = 0;
	int n_failed = 0;

	mod_periph_top DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	//--------------------------------------------------------------------------
	// Helpers
	//--------------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;                                 // Registered outputs settled
	endtask

	task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] actual,
		input logic [DATA_WIDTH-1:0] expected);
		checks++;
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		n_tests++;
		if (errors != errs_before)
			n_failed++;
		$display("Test %0d %s: %s", n_tests, name, (errors == errs_before) ? "passed" : "FAILED");
	endtask

	task automatic add_case(input logic [A_WIDTH-1:0] a, input logic [B_WIDTH-1:0] b,
		input logic tc, input op_e op, input logic [DATA_WIDTH-1:0] exp_word,
		input logic exp_zero, input logic [1:0] exp_resp);
		tbl_a.push_back(a);
		tbl_b.push_back(b);
		tbl_tc.push_back(tc);
		tbl_op.push_back(op);
		tbl_exp.push_back(exp_word);
		tbl_zero.push_back(exp_zero);
		tbl_resp.push_back(exp_resp);
	endtask

	// VHDL mod/rem on integers, % only ever sees magnitudes
	task automatic compute_expected(input logic [A_WIDTH-1:0] a, input logic [B_WIDTH-1:0] b,
		input logic tc, input op_e op, output logic [DATA_WIDTH-1:0] exp_word,
		output logic exp_zero);
		int av;
		int bv;
		int am;
		int bm;
		int r;
		int res;
		av = tc ? int'($signed(a)) : int'(a);
		bv = tc ? int'($signed(b)) : int'(b);
		am = (av < 0) ? -av : av;
		bm = (bv < 0) ? -bv : bv;
		exp_zero = (bv == 0);
		res = 0;
		if (bv != 0)
		begin
			r = am % bm;
			if (op == OP_REM)
				res = (av < 0) ? -r : r;             // Dividend sign
			else if ((r != 0) && ((av < 0) != (bv < 0)))
				res = (bv < 0) ? -(bm - r) : bm - r;
			else
				res = (bv < 0) ? -r : r;             // Divisor sign
		end
		exp_word = DATA_WIDTH'(res);            // Fits 9 bits, so 32-bit form is the extension
	endtask

	//--------------------------------------------------------------------------
	// AXI4-Lite master
	//--------------------------------------------------------------------------
	task automatic write_reg(input logic [ADDR_WIDTH-1:0] addr,
		input logic [DATA_WIDTH-1:0] data, input int hold, output logic [1:0] resp);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		next_cycle();
		while (!(awready && wready))
			next_cycle();
		next_cycle();                           // Handshake edge
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			next_cycle();
		repeat (hold) next_cycle();             // Back-pressure on B only
		if (hold > 0)
			check_value("bvalid held", DATA_WIDTH'(bvalid), 1);
		resp   = bresp;
		bready = 1'b1;
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [ADDR_WIDTH-1:0] addr, input int hold,
		output logic [DATA_WIDTH-1:0] data, output logic [1:0] resp);
		araddr  = addr;
		arvalid = 1'b1;
		next_cycle();
		while (!arready)
			next_cycle();
		next_cycle();
		arvalid = 1'b0;
		while (!rvalid)
			next_cycle();
		repeat (hold) next_cycle();             // Back-pressure on R only
		if (hold > 0)
			check_value("rvalid held", DATA_WIDTH'(rvalid), 1);
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		next_cycle();
		rready = 1'b0;
	endtask

	task automatic wait_done();
		logic [DATA_WIDTH-1:0] data;
		logic [1:0]            resp;
		int                    polls;
		polls = 0;
		data  = '0;
		while (!data[1] && (polls < MAX_POLLS))
		begin
			read_reg(REG_STATUS, 0, data, resp);
			polls++;
		end
		if (!data[1])
		begin
			$display("STATUS.done still low after %0d polls", polls);
			errors++;
		end
	endtask

	task automatic run_case(input logic [A_WIDTH-1:0] a, input logic [B_WIDTH-1:0] b,
		input logic tc, input op_e op, input logic [DATA_WIDTH-1:0] exp_word,
		input logic exp_zero, input logic [1:0] exp_resp);
		logic [DATA_WIDTH-1:0] data;
		logic [1:0]            resp;
		int                    errs_before;
		errs_before = errors;
		write_reg(REG_A, DATA_WIDTH'(a), 0, resp);
		check_value("A write response", resp, exp_resp);
		write_reg(REG_B, DATA_WIDTH'(b), 0, resp);
		check_value("B write response", resp, exp_resp);
		write_reg(REG_CTRL, DATA_WIDTH'({op, tc, 1'b1}), 0, resp);
		check_value("CTRL write response", resp, exp_resp);
		wait_done();
		read_reg(REG_RESULT, 0, data, resp);
		check_value("RESULT", data, exp_word);
		check_value("RESULT read response", resp, exp_resp);
		read_reg(REG_STATUS, 0, data, resp);
		check_value("STATUS", data, DATA_WIDTH'({exp_zero, 2'b10}));  // done set, idle
		report_test($sformatf("a=%h b=%h tc=%0d op=%0d", a, b, tc, op), errs_before);
	endtask

	//--------------------------------------------------------------------------
	// Main sequence
	//--------------------------------------------------------------------------
	initial
	begin
		logic [A_WIDTH-1:0]    ra;
		logic [B_WIDTH-1:0]    rb;
		logic                  rtc;
		op_e                   rop;
		logic [DATA_WIDTH-1:0] rexp;
		logic                  rzero;
		logic [DATA_WIDTH-1:0] data;
		logic [1:0]            resp;
		int                    errs_before;
		rst_n   = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '1;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;

		// Unsigned, mod and rem agree
		add_case(14'd1000,  9'd7,   1'b0, OP_MOD, 32'd6,  1'b0, RESP_OKAY);
		add_case(14'd1000,  9'd7,   1'b0, OP_REM, 32'd6,  1'b0, RESP_OKAY);
		add_case(14'd16383, 9'd511, 1'b0, OP_MOD, 32'd31, 1'b0, RESP_OKAY);
		add_case(14'd16383, 9'd511, 1'b0, OP_REM, 32'd31, 1'b0, RESP_OKAY);
		// Signed mod, sign of divisor
		add_case(14'h3FF9, 9'h003, 1'b1, OP_MOD, 32'd2,        1'b0, RESP_OKAY);  // -7 mod 3
		add_case(14'h0007, 9'h1FD, 1'b1, OP_MOD, 32'hFFFFFFFE, 1'b0, RESP_OKAY);  // 7 mod -3
		add_case(14'h3FF9, 9'h1FD, 1'b1, OP_MOD, 32'hFFFFFFFF, 1'b0, RESP_OKAY);  // -7 mod -3
		add_case(14'h0007, 9'h003, 1'b1, OP_MOD, 32'd1,        1'b0, RESP_OKAY);
		add_case(14'h3FFA, 9'h003, 1'b1, OP_MOD, 32'd0,        1'b0, RESP_OKAY);  // -6 mod 3
		add_case(14'h0006, 9'h1FD, 1'b1, OP_MOD, 32'd0,        1'b0, RESP_OKAY);
		add_case(14'h2000, 9'h0FF, 1'b1, OP_MOD, 32'd223,      1'b0, RESP_OKAY);  // -8192 mod 255
		// Signed rem, sign of dividend
		add_case(14'h3FF9, 9'h003, 1'b1, OP_REM, 32'hFFFFFFFF, 1'b0, RESP_OKAY);  // -7 rem 3
		add_case(14'h0007, 9'h1FD, 1'b1, OP_REM, 32'd1,        1'b0, RESP_OKAY);
		add_case(14'h3FF9, 9'h1FD, 1'b1, OP_REM, 32'hFFFFFFFF, 1'b0, RESP_OKAY);
		add_case(14'h0007, 9'h003, 1'b1, OP_REM, 32'd1,        1'b0, RESP_OKAY);
		add_case(14'h1FFF, 9'h100, 1'b1, OP_REM, 32'd255,      1'b0, RESP_OKAY);  // 8191 rem -256
		// Zero divisor, then a valid op clears the flag
		add_case(14'd100,  9'd0,   1'b0, OP_MOD, 32'd0, 1'b1, RESP_OKAY);
		add_case(14'h3FFB, 9'h000, 1'b1, OP_REM, 32'd0, 1'b1, RESP_OKAY);
		add_case(14'd100,  9'd7,   1'b0, OP_MOD, 32'd2, 1'b0, RESP_OKAY);
		tbl_ready = 1'b1;

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		for (int i = 0; i < tbl_a.size(); i++)
			run_case(tbl_a[i], tbl_b[i], tbl_tc[i], tbl_op[i], tbl_exp[i], tbl_zero[i], tbl_resp[i]);

		for (int i = 0; i < N_RANDOM; i++)
		begin
			ra  = A_WIDTH'($random(seed));
			rb  = B_WIDTH'($random(seed));
			rtc = $random(seed) & 1;
			rop = op_e'($random(seed) & 1);
			compute_expected(ra, rb, rtc, rop, rexp, rzero);
			run_case(ra, rb, rtc, rop, rexp, rzero, RESP_OKAY);
		end

		// Unmapped offset on both channels
		errs_before = errors;
		read_reg(5'h14, 0, data, resp);
		check_value("unmapped read data", data, 0);
		check_value("unmapped read response", resp, RESP_SLVERR);
		write_reg(5'h14, 32'h1234, 0, resp);
		check_value("unmapped write response", resp, RESP_SLVERR);
		report_test("unmapped offset", errs_before);

		// Second go while busy must be dropped, B and R held under back-pressure
		errs_before = errors;
		write_reg(REG_A, 32'd1000, 0, resp);
		write_reg(REG_B, 32'd7, 0, resp);
		write_reg(REG_CTRL, 32'h1, 0, resp);
		write_reg(REG_A, 32'd50, 0, resp);       // 50 mod 7 would give 1
		write_reg(REG_CTRL, 32'h1, 3, resp);
		check_value("go while busy response", resp, RESP_OKAY);
		wait_done();
		read_reg(REG_RESULT, 5, data, resp);
		check_value("RESULT after ignored go", data, 32'd6);
		read_reg(REG_STATUS, 0, data, resp);
		check_value("STATUS after ignored go", data, 32'h2);
		report_test("go while busy, bready and rready held low", errs_before);

		$display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog, about 40 cycles per operation with slack
	initial
	begin
		wait (tbl_ready);
		repeat ((tbl_a.size() + N_RANDOM + 4) * 40) @(posedge clk);
		$display("Timeout: the tests did not finish in the allowed number of cycles");
		$display("Errors found");
		$finish;
	end

endmodule

// ==== sources.f ====
src/mod_pkg.sv
src/nr_divider.sv
src/mod_unit.sv
src/axil_mod_regs.sv
src/mod_periph_top.sv
dv/mod_periph_assertions.sv
dv/tb_mod_periph.sv

// ==== Bender.yml ====
package:
  name: mod_periph

sources:
  # RTL, package first
  - src/mod_pkg.sv
  - src/nr_divider.sv
  - src/mod_unit.sv
  - src/axil_mod_regs.sv
  - src/mod_periph_top.sv

  # Testbench and bound assertions
  - target: simulation
    files:
      - dv/mod_periph_assertions.sv
      - dv/tb_mod_periph.sv
